/* source/main_pkg.sv */
// Main CPU glue package with bus widths, address-map regions and register offsets
`default_nettype none

package main_pkg;

    // Bus widths
    localparam int ADDR_W = 16;
    localparam int DATA_W = 8;
    localparam int ROM_AW = 18;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ROM_AW-1:0] rom_addr_t;

    // Decoded bus target
    typedef enum logic [3:0] {
        rgn_ram,
        rgn_pal,
        rgn_char,
        rgn_com,
        rgn_obj,
        rgn_scr,
        rgn_io,
        rgn_rom_fixed,
        rgn_rom_banked,
        rgn_none
    } region_t;

    // Write offsets inside 0x3808-0x380F, A[2:0]
    localparam int WR_MISC     = 0;
    localparam int WR_HSCROLL  = 1;
    localparam int WR_VSCROLL  = 2;
    localparam int WR_NMI_CLR  = 3;
    localparam int WR_FIRQ_CLR = 4;
    localparam int WR_IRQ_CLR  = 5;
    localparam int WR_SOUND    = 6;
    localparam int WR_MCU_NMI  = 7;

    // Interrupt vector bit positions
    localparam int IRQ_NMI  = 2;
    localparam int IRQ_FIRQ = 1;
    localparam int IRQ_IRQ  = 0;

endpackage

`default_nettype wire

/* source/main_decode.sv */
// Main CPU address decoder with ROM addressing, read mux and Wishbone acknowledge
`timescale 1ns/100ps
`default_nettype none

module main_decode (
    input  logic                clk,
    input  logic                rst,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  main_pkg::addr_t     wb_adr,
    input  main_pkg::data_t     ram_dout,
    input  main_pkg::data_t     pal_dout,
    input  main_pkg::data_t     char_dout,
    input  main_pkg::data_t     com_dout,
    input  main_pkg::data_t     obj_dout,
    input  main_pkg::data_t     scr_dout,
    input  main_pkg::data_t     cab_dout,
    input  main_pkg::data_t     rom_data,
    input  logic                rom_ok,
    input  logic [2:0]          bank,
    output logic                wb_ack,
    output main_pkg::data_t     wb_dat_r,
    output logic                ram_we,
    output logic                pal_cs,
    output logic                char_cs,
    output logic                com_cs,
    output logic                obj_cs,
    output logic                scr_cs,
    output logic                rom_cs,
    output main_pkg::rom_addr_t rom_addr,
    output logic [7:0]          reg_wr
);
    import main_pkg::*;

    region_t region;
    logic    banked;
    logic    go;
    logic    ack_ram;
    data_t   mux_dout;
    data_t   dat_q;

    // Region only valid while a cycle is strobed
    always_comb begin
        region = rgn_none;
        if (wb_cyc && wb_stb) begin
            if (wb_adr[15]) begin
                region = rgn_rom_fixed;
            end else if (wb_adr[14]) begin
                region = rgn_rom_banked;
            end else begin
                // 2 KB windows below 0x4000
                case (wb_adr[13:11])
                    3'd0, 3'd1: region = rgn_ram;
                    3'd2:       region = rgn_pal;
                    3'd3:       region = rgn_char;
                    3'd4:       region = rgn_com;
                    3'd5:       region = rgn_obj;
                    3'd6:       region = rgn_scr;
                    default:    region = rgn_io;
                endcase
            end
        end
    end

    assign banked  = (region == rgn_rom_banked);
    assign pal_cs  = (region == rgn_pal);
    assign char_cs = (region == rgn_char);
    assign com_cs  = (region == rgn_com);
    assign obj_cs  = (region == rgn_obj);
    assign scr_cs  = (region == rgn_scr);
    assign rom_cs  = banked || (region == rgn_rom_fixed);

    // Banked window gets 0+bank, fixed window 100+A14
    assign rom_addr = banked ? {1'b0, bank, wb_adr[13:0]} : {3'b100, wb_adr[14:0]};

    // ROM waits for rom_ok, every other target answers at once
    assign go = rom_cs ? rom_ok : (region != rgn_none);

    // Writes land in the ack cycle, at the edge the master sees ack
    assign ram_we = wb_ack && wb_we && (region == rgn_ram);
    assign reg_wr = (wb_ack && wb_we && (region == rgn_io) && wb_adr[3]) ?
                    (8'd1 << wb_adr[2:0]) : 8'd0;

    always_comb begin
        case (region)
            rgn_pal:        mux_dout = pal_dout;
            rgn_char:       mux_dout = char_dout;
            rgn_com:        mux_dout = com_dout;
            rgn_obj:        mux_dout = obj_dout;
            rgn_scr:        mux_dout = scr_dout;
            rgn_io:         mux_dout = cab_dout;
            rgn_rom_fixed:  mux_dout = rom_data;
            rgn_rom_banked: mux_dout = rom_data;
            default:        mux_dout = 8'hff;
        endcase
    end

    // One-cycle ack pulse, a held strobe restarts after it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack  <= 1'b0;
            ack_ram <= 1'b0;
        end else begin
            wb_ack  <= go && !wb_ack;
            ack_ram <= go && !wb_ack && (region == rgn_ram);
        end
    end

    // Read byte captured together with the ack
    always_ff @(posedge clk) begin
        if (go && !wb_ack) begin
            dat_q <= mux_dout;
        end
    end

    // RAM output is already registered on the same edge
    assign wb_dat_r = ack_ram ? ram_dout : dat_q;

endmodule

`default_nettype wire

/* source/main_regs.sv */
// Main CPU control latches for scroll, flip, ROM bank, MCU control and sound latch
`timescale 1ns/100ps
`default_nettype none

module main_regs (
    input  logic            clk,
    input  logic            rst,
    input  logic [7:0]      reg_wr,
    input  main_pkg::data_t wb_dat_w,
    output logic [8:0]      scrhpos,
    output logic [8:0]      scrvpos,
    output logic            flip,
    output logic            mcu_rstb,
    output logic            mcu_halt,
    output logic [2:0]      bank,
    output main_pkg::data_t snd_latch,
    output logic            snd_irq,
    output logic            mcu_nmi_set
);
    import main_pkg::*;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scrhpos     <= 9'd0;
            scrvpos     <= 9'd0;
            flip        <= 1'b0;
            mcu_rstb    <= 1'b0;
            mcu_halt    <= 1'b0;
            bank        <= 3'd0;
            snd_irq     <= 1'b0;
            mcu_nmi_set <= 1'b0;
        end else begin
            // Low scroll bytes
            if (reg_wr[WR_HSCROLL]) begin
                scrhpos[7:0] <= wb_dat_w;
            end
            if (reg_wr[WR_VSCROLL]) begin
                scrvpos[7:0] <= wb_dat_w;
            end
            // Misc byte fans out to scroll MSBs and board control
            if (reg_wr[WR_MISC]) begin
                scrhpos[8] <= wb_dat_w[0];
                scrvpos[8] <= wb_dat_w[1];
                flip       <= wb_dat_w[2];
                mcu_rstb   <= wb_dat_w[3];
                mcu_halt   <= wb_dat_w[4];
                bank       <= wb_dat_w[7:5];
            end
            // Single-cycle strobes toward sound CPU and MCU
            snd_irq     <= reg_wr[WR_SOUND];
            mcu_nmi_set <= reg_wr[WR_MCU_NMI];
        end
    end

    // Sound command byte
    always_ff @(posedge clk) begin
        if (reg_wr[WR_SOUND]) begin
            snd_latch <= wb_dat_w;
        end
    end

endmodule

`default_nettype wire

/* source/irq_latch.sv */
// Edge-set, write-cleared interrupt flip-flop bank
`timescale 1ns/100ps
`default_nettype none

module irq_latch #(
    parameter int W = 3
) (
    input  logic         clk,
    input  logic         rst,
    input  logic [W-1:0] sigedge,
    input  logic [W-1:0] clr,
    output logic [W-1:0] q
);

    logic [W-1:0] prev;
    logic [W-1:0] rise;

    // Source history, follows the inputs even in reset
    always_ff @(posedge clk) begin
        prev <= sigedge;
    end

    assign rise = sigedge & ~prev;

    // A new edge wins over a clear in the same cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            q <= '0;
        end else begin
            q <= rise | (q & ~clr);
        end
    end

endmodule

`default_nettype wire

/* source/work_ram.sv */
// Main CPU 4 KB work RAM, single port with registered read
`timescale 1ns/100ps
`default_nettype none

module work_ram (
    input  logic            clk,
    input  logic            we,
    input  logic [11:0]     addr,
    input  main_pkg::data_t din,
    output main_pkg::data_t dout
);
    import main_pkg::*;

    data_t mem [0:4095];

    // Read sampled on the strobe edge, lands in the ack cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
        end
        dout <= mem[addr];
    end

endmodule

`default_nettype wire

/* source/cabinet_io.sv */
// Cabinet input and DIP switch byte selection for the main CPU
`timescale 1ns/100ps
`default_nettype none

module cabinet_io (
    input  logic [1:0]      start_button,
    input  logic [1:0]      coin_input,
    input  logic [6:0]      joystick1,
    input  logic [6:0]      joystick2,
    input  logic            service,
    input  logic            vbl,
    input  logic            mcu_ban,
    input  main_pkg::data_t dipsw_a,
    input  main_pkg::data_t dipsw_b,
    input  logic [2:0]      sel,
    output main_pkg::data_t cab_dout
);
    import main_pkg::*;

    data_t status;

    // Board wires joystick bits 2 and 3 crossed
    function automatic logic [5:0] swap_joy(input logic [5:0] joy);
        swap_joy = {joy[5:4], joy[2], joy[3], joy[1:0]};
    endfunction

    // Top three bits read as ones
    assign status = {3'b111, mcu_ban, vbl, joystick2[6], joystick1[6], service};

    always_comb begin
        case (sel)
            3'd0:    cab_dout = {start_button, swap_joy(joystick1[5:0])};
            3'd1:    cab_dout = {coin_input, swap_joy(joystick2[5:0])};
            3'd2:    cab_dout = status;
            3'd3:    cab_dout = dipsw_a;
            3'd4:    cab_dout = dipsw_b;
            default: cab_dout = 8'hff;
        endcase
    end

endmodule

`default_nettype wire

/* source/main_bus.sv */
// Main CPU bus subsystem top, Wishbone slave to RAM, ROM, video and control
`timescale 1ns/100ps
`default_nettype none

module main_bus #(
    parameter int IRQ_W = 3
) (
    input  logic                clk,
    input  logic                rst,
    // Wishbone classic slave
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  main_pkg::addr_t     wb_adr,
    input  main_pkg::data_t     wb_dat_w,
    output logic                wb_ack,
    output main_pkg::data_t     wb_dat_r,
    // Video memory selects
    output logic                pal_cs,
    output logic                char_cs,
    output logic                com_cs,
    output logic                obj_cs,
    output logic                scr_cs,
    input  main_pkg::data_t     pal_dout,
    input  main_pkg::data_t     char_dout,
    input  main_pkg::data_t     com_dout,
    input  main_pkg::data_t     obj_dout,
    input  main_pkg::data_t     scr_dout,
    // External program ROM
    output logic                rom_cs,
    output main_pkg::rom_addr_t rom_addr,
    input  main_pkg::data_t     rom_data,
    input  logic                rom_ok,
    // Control latches
    output logic [8:0]          scrhpos,
    output logic [8:0]          scrvpos,
    output logic                flip,
    output logic                mcu_rstb,
    output logic                mcu_halt,
    output logic [2:0]          bank,
    output main_pkg::data_t     snd_latch,
    output logic                snd_irq,
    output logic                mcu_nmi_set,
    // Cabinet
    input  logic [1:0]          start_button,
    input  logic [1:0]          coin_input,
    input  logic [6:0]          joystick1,
    input  logic [6:0]          joystick2,
    input  logic                service,
    input  logic                mcu_ban,
    input  main_pkg::data_t     dipsw_a,
    input  main_pkg::data_t     dipsw_b,
    // Interrupt sources and outputs
    input  logic                vbl,
    input  logic                ims,
    input  logic                mcu_irqmain,
    input  logic                dip_pause,
    output logic                nmi,
    output logic                firq,
    output logic                irq
);
    import main_pkg::*;

    data_t            ram_dout;
    data_t            cab_dout;
    logic             ram_we;
    logic [7:0]       reg_wr;
    logic [IRQ_W-1:0] irq_src;
    logic [IRQ_W-1:0] irq_clr;
    logic [IRQ_W-1:0] irq_q;

    // NMI only from VBL when pause DIP allows it
    assign irq_src[IRQ_NMI]  = vbl & dip_pause;
    assign irq_src[IRQ_FIRQ] = ims;
    assign irq_src[IRQ_IRQ]  = mcu_irqmain;
    assign irq_clr[IRQ_NMI]  = reg_wr[WR_NMI_CLR];
    assign irq_clr[IRQ_FIRQ] = reg_wr[WR_FIRQ_CLR];
    assign irq_clr[IRQ_IRQ]  = reg_wr[WR_IRQ_CLR];
    assign nmi  = irq_q[IRQ_NMI];
    assign firq = irq_q[IRQ_FIRQ];
    assign irq  = irq_q[IRQ_IRQ];

    main_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .ram_dout  (ram_dout),
        .pal_dout  (pal_dout),
        .char_dout (char_dout),
        .com_dout  (com_dout),
        .obj_dout  (obj_dout),
        .scr_dout  (scr_dout),
        .cab_dout  (cab_dout),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .bank      (bank),
        .wb_ack    (wb_ack),
        .wb_dat_r  (wb_dat_r),
        .ram_we    (ram_we),
        .pal_cs    (pal_cs),
        .char_cs   (char_cs),
        .com_cs    (com_cs),
        .obj_cs    (obj_cs),
        .scr_cs    (scr_cs),
        .rom_cs    (rom_cs),
        .rom_addr  (rom_addr),
        .reg_wr    (reg_wr)
    );

    main_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .reg_wr      (reg_wr),
        .wb_dat_w    (wb_dat_w),
        .scrhpos     (scrhpos),
        .scrvpos     (scrvpos),
        .flip        (flip),
        .mcu_rstb    (mcu_rstb),
        .mcu_halt    (mcu_halt),
        .bank        (bank),
        .snd_latch   (snd_latch),
        .snd_irq     (snd_irq),
        .mcu_nmi_set (mcu_nmi_set)
    );

    irq_latch #(
        .W (IRQ_W)
    ) u_irq (
        .clk     (clk),
        .rst     (rst),
        .sigedge (irq_src),
        .clr     (irq_clr),
        .q       (irq_q)
    );

    work_ram u_ram (
        .clk  (clk),
        .we   (ram_we),
        .addr (wb_adr[11:0]),
        .din  (wb_dat_w),
        .dout (ram_dout)
    );

    cabinet_io u_cab (
        .start_button (start_button),
        .coin_input   (coin_input),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .service      (service),
        .vbl          (vbl),
        .mcu_ban      (mcu_ban),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .sel          (wb_adr[2:0]),
        .cab_dout     (cab_dout)
    );

endmodule

`default_nettype wire

/* tests/main_bus_chk.sv */
// Bus checker bound to the main bus top for handshake, strobe and reset-state assertions
`timescale 1ns/100ps
`default_nettype none

module main_bus_chk (
    input logic       clk,
    input logic       rst,
    input logic       wb_cyc,
    input logic       wb_stb,
    input logic       wb_ack,
    input logic       snd_irq,
    input logic       mcu_nmi_set,
    input logic       nmi,
    input logic       firq,
    input logic       irq,
    input logic       flip,
    input logic       mcu_rstb,
    input logic       mcu_halt,
    input logic [2:0] bank,
    input logic [8:0] scrhpos,
    input logic [8:0] scrvpos
);

    // Count of failed assertions, read by the testbench
    int fail_count = 0;

    // Ack is a single-cycle pulse
    ack_pulse: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else begin
            fail_count++;
            $error("wb_ack stayed high for two cycles");
        end

    // Ack only answers a strobed cycle
    ack_after_stb: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else begin
            fail_count++;
            $error("wb_ack without a preceding strobe");
        end

    // Sound strobe
    snd_pulse: assert property (@(posedge clk) disable iff (rst) snd_irq |=> !snd_irq)
        else begin
            fail_count++;
            $error("snd_irq longer than one cycle");
        end

    // Everything quiet while reset is held
    reset_quiet: assert property (@(posedge clk)
        rst |-> !wb_ack && !snd_irq && !mcu_nmi_set && !nmi && !firq && !irq &&
                !flip && !mcu_rstb && !mcu_halt && bank == 3'd0 &&
                scrhpos == 9'd0 && scrvpos == 9'd0)
        else begin
            fail_count++;
            $error("control outputs not low during reset");
        end

endmodule

bind main_bus main_bus_chk u_chk (.*);

`default_nettype wire

/* tests/tb_main_bus.sv */
// Random-stimulus testbench for the main CPU bus with ROM, video and cabinet models
`timescale 1ns/100ps
`default_nettype none

module tb_main_bus;
    import main_pkg::*;

    localparam int N_RAM        = 300;
    localparam int N_REG        = 60;
    localparam int N_ROM        = 60;
    localparam int N_VID        = 40;
    localparam int N_IO         = 40;
    localparam int N_IRQ        = 60;
    localparam int ROM_WAIT_MAX = 7;
    // ROM loop may add a misc write, IRQ loop up to two writes plus an idle
    localparam int N_TXN        = N_RAM + 2 * N_REG + 2 * N_ROM + N_VID + N_IO + 4 * N_IRQ + 3;
    localparam int CYCLE_LIMIT  = N_TXN * (ROM_WAIT_MAX + 4) + 200;

    logic            clk;
    logic            rst;
    logic            wb_cyc;
    logic            wb_stb;
    logic            wb_we;
    addr_t           wb_adr;
    data_t           wb_dat_w;
    logic            wb_ack;
    data_t           wb_dat_r;
    logic            pal_cs;
    logic            char_cs;
    logic            com_cs;
    logic            obj_cs;
    logic            scr_cs;
    data_t           pal_dout;
    data_t           char_dout;
    data_t           com_dout;
    data_t           obj_dout;
    data_t           scr_dout;
    logic            rom_cs;
    rom_addr_t       rom_addr;
    data_t           rom_data;
    logic            rom_ok;
    logic [8:0]      scrhpos;
    logic [8:0]      scrvpos;
    logic            flip;
    logic            mcu_rstb;
    logic            mcu_halt;
    logic [2:0]      bank;
    data_t           snd_latch;
    logic            snd_irq;
    logic            mcu_nmi_set;
    logic [1:0]      start_button;
    logic [1:0]      coin_input;
    logic [6:0]      joystick1;
    logic [6:0]      joystick2;
    logic            service;
    logic            mcu_ban;
    data_t           dipsw_a;
    data_t           dipsw_b;
    logic            vbl;
    logic            ims;
    logic            mcu_irqmain;
    logic            dip_pause;
    logic            nmi;
    logic            firq;
    logic            irq;

    // Reference model state
    data_t           ram_model [0:4095];
    addr_t           ram_written [$];
    logic [8:0]      exp_hpos;
    logic [8:0]      exp_vpos;
    logic            exp_flip;
    logic            exp_rstb;
    logic            exp_halt;
    logic [2:0]      exp_bank;
    data_t           exp_snd;
    logic            snd_valid;
    logic [2:0]      exp_irqv;
    logic [2:0]      prev_src;
    logic [15:0]     lfsr_state = 16'd55;
    int              cycle_count = 0;
    string           test_name = "init";

    main_bus #(.IRQ_W(3)) uut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %s %s expected 0x%0h actual 0x%0h",
                                test_name, what, expected, actual));
        end
    endtask

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            abort_run($sformatf("Timeout after %0d cycles, the bus stopped answering",
                                cycle_count));
        end
    end

    always @(negedge clk) begin
        if (uut.u_chk.fail_count != 0) begin
            abort_run("A bound assertion on the bus failed");
        end
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 16'hb400;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Select vector {pal, char, com, obj, scr, rom} by address range
    function automatic logic [5:0] expected_selects(input addr_t a);
        logic [5:0] s;
        s = 6'b0;
        if (a >= 16'h4000) begin
            s[0] = 1'b1;
        end else if (a >= 16'h3800) begin
            s = 6'b0;
        end else if (a >= 16'h3000) begin
            s[1] = 1'b1;
        end else if (a >= 16'h2800) begin
            s[2] = 1'b1;
        end else if (a >= 16'h2000) begin
            s[3] = 1'b1;
        end else if (a >= 16'h1800) begin
            s[4] = 1'b1;
        end else if (a >= 16'h1000) begin
            s[5] = 1'b1;
        end
        return s;
    endfunction

    function automatic rom_addr_t rom_map(input addr_t a);
        rom_addr_t r;
        if (a >= 16'h8000) begin
            r = {3'b100, a[14:0]};
        end else begin
            r = {1'b0, exp_bank, a[13:0]};
        end
        return r;
    endfunction

    // ROM contents, every address bit contributes
    function automatic data_t rom_byte(input rom_addr_t a);
        return a[7:0] ^ {a[14:8], a[15]} ^ {4'h3, a[17:16], 2'b01};
    endfunction

    function automatic data_t cabinet_byte(input logic [2:0] off);
        data_t b;
        case (off)
            3'd0: begin
                b    = {start_button, joystick1[5:0]};
                b[3] = joystick1[2];
                b[2] = joystick1[3];
            end
            3'd1: begin
                b    = {coin_input, joystick2[5:0]};
                b[3] = joystick2[2];
                b[2] = joystick2[3];
            end
            3'd2:    b = {3'b111, mcu_ban, vbl, joystick2[6], joystick1[6], service};
            3'd3:    b = dipsw_a;
            3'd4:    b = dipsw_b;
            default: b = 8'hff;
        endcase
        return b;
    endfunction

    function automatic logic [2:0] source_levels();
        logic [2:0] s;
        s[IRQ_NMI]  = vbl & dip_pause;
        s[IRQ_FIRQ] = ims;
        s[IRQ_IRQ]  = mcu_irqmain;
        return s;
    endfunction

    // One Wishbone cycle, ROM answers after rom_wait cycles
    task automatic bus_cycle(input logic we, input addr_t adr, input data_t wdat,
                             input int rom_wait, output data_t rdat);
        int         n;
        logic       done;
        logic       is_rom;
        logic [5:0] sel_exp;
        n        = 0;
        done     = 1'b0;
        is_rom   = (adr >= 16'h4000);
        sel_exp  = expected_selects(adr);
        rdat     = 8'h00;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        rom_data = data_t'(lfsr_bits(8));
        while (!done) begin
            @(negedge clk);
            n++;
            check_value("select", 32'(sel_exp),
                        32'({pal_cs, char_cs, com_cs, obj_cs, scr_cs, rom_cs}));
            if (wb_ack === 1'b1) begin
                done = 1'b1;
                rdat = wb_dat_r;
            end else if (is_rom) begin
                check_value("rom_addr", 32'(rom_map(adr)), 32'(rom_addr));
                // ROM model looks up what the DUT presents
                if (n > rom_wait) begin
                    rom_ok   = 1'b1;
                    rom_data = rom_byte(rom_addr);
                end
            end
        end
        check_value("ack latency", 32'(is_rom ? rom_wait + 2 : 1), 32'(n));
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        rom_ok = 1'b0;
    endtask

    task automatic check_regs();
        check_value("scrhpos", 32'(exp_hpos), 32'(scrhpos));
        check_value("scrvpos", 32'(exp_vpos), 32'(scrvpos));
        check_value("flip", 32'(exp_flip), 32'(flip));
        check_value("mcu_rstb", 32'(exp_rstb), 32'(mcu_rstb));
        check_value("mcu_halt", 32'(exp_halt), 32'(mcu_halt));
        check_value("bank", 32'(exp_bank), 32'(bank));
        check_value("interrupts", 32'(exp_irqv), 32'({nmi, firq, irq}));
        if (snd_valid) begin
            check_value("snd_latch", 32'(exp_snd), 32'(snd_latch));
        end
    endtask

    // Write to 0x3808-0x380F with random don't-care address bits
    task automatic reg_write(input int off, input data_t d);
        logic [6:0] mid;
        addr_t      a;
        data_t      rd;
        mid = 7'(lfsr_bits(7));
        a   = {5'b00111, mid, 1'b1, 3'(off)};
        bus_cycle(1'b1, a, d, 0, rd);
        case (off)
            WR_MISC: begin
                exp_hpos[8] = d[0];
                exp_vpos[8] = d[1];
                exp_flip    = d[2];
                exp_rstb    = d[3];
                exp_halt    = d[4];
                exp_bank    = d[7:5];
            end
            WR_HSCROLL:  exp_hpos[7:0] = d;
            WR_VSCROLL:  exp_vpos[7:0] = d;
            WR_NMI_CLR:  exp_irqv[IRQ_NMI] = 1'b0;
            WR_FIRQ_CLR: exp_irqv[IRQ_FIRQ] = 1'b0;
            WR_IRQ_CLR:  exp_irqv[IRQ_IRQ] = 1'b0;
            WR_SOUND: begin
                exp_snd   = d;
                snd_valid = 1'b1;
            end
            default: ;
        endcase
        // Strobes show in the cycle after the write edge only
        check_value("snd_irq pulse", 32'(off == WR_SOUND), 32'(snd_irq));
        check_value("mcu_nmi_set pulse", 32'(off == WR_MCU_NMI), 32'(mcu_nmi_set));
        check_regs();
        @(negedge clk);
        check_value("snd_irq end", 32'd0, 32'(snd_irq));
        check_value("mcu_nmi_set end", 32'd0, 32'(mcu_nmi_set));
    endtask

    initial begin
        addr_t       a;
        data_t       d;
        data_t       rd;
        data_t       exp_d;
        int          idx;
        int          win;
        int          wait_n;
        logic [31:0] sel;
        logic [2:0]  src;
        rst          = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        pal_dout     = '0;
        char_dout    = '0;
        com_dout     = '0;
        obj_dout     = '0;
        scr_dout     = '0;
        rom_data     = '0;
        rom_ok       = 1'b0;
        start_button = '0;
        coin_input   = '0;
        joystick1    = '0;
        joystick2    = '0;
        service      = 1'b0;
        mcu_ban      = 1'b0;
        dipsw_a      = '0;
        dipsw_b      = '0;
        vbl          = 1'b0;
        ims          = 1'b0;
        mcu_irqmain  = 1'b0;
        dip_pause    = 1'b0;
        exp_hpos     = '0;
        exp_vpos     = '0;
        exp_flip     = 1'b0;
        exp_rstb     = 1'b0;
        exp_halt     = 1'b0;
        exp_bank     = '0;
        exp_snd      = '0;
        snd_valid    = 1'b0;
        exp_irqv     = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_name = "reset";
        @(negedge clk);
        check_value("wb_ack", 32'd0, 32'(wb_ack));
        check_value("snd_irq", 32'd0, 32'(snd_irq));
        check_value("mcu_nmi_set", 32'd0, 32'(mcu_nmi_set));
        check_regs();

        // Reads only from addresses already written
        test_name = "ram";
        for (int i = 0; i < N_RAM; i++) begin
            if (ram_written.size() == 0 || lfsr_bits(1) == 32'd1) begin
                a = addr_t'(lfsr_bits(12));
                d = data_t'(lfsr_bits(8));
                bus_cycle(1'b1, a, d, 0, rd);
                ram_model[a[11:0]] = d;
                ram_written.push_back(a);
            end else begin
                idx = int'(lfsr_bits(10)) % ram_written.size();
                a   = ram_written[idx];
                bus_cycle(1'b0, a, 8'h00, 0, rd);
                check_value("read data", 32'(ram_model[a[11:0]]), 32'(rd));
            end
        end

        // Scroll, misc and sound writes
        test_name = "registers";
        for (int i = 0; i < N_REG; i++) begin
            sel = lfsr_bits(2);
            if (sel == 32'd3) begin
                reg_write(WR_SOUND, data_t'(lfsr_bits(8)));
            end else begin
                reg_write(int'(sel), data_t'(lfsr_bits(8)));
            end
        end

        // Bank moves now and then through misc writes
        test_name = "rom";
        for (int i = 0; i < N_ROM; i++) begin
            if (lfsr_bits(2) == 32'd0) begin
                reg_write(WR_MISC, data_t'(lfsr_bits(8)));
            end
            if (lfsr_bits(1) == 32'd1) begin
                a = {2'b01, 14'(lfsr_bits(14))};
            end else begin
                a = {1'b1, 15'(lfsr_bits(15))};
            end
            wait_n = int'(lfsr_bits(3));
            bus_cycle(1'b0, a, 8'h00, wait_n, rd);
            check_value("read data", 32'(rom_byte(rom_map(a))), 32'(rd));
        end

        test_name = "video";
        for (int i = 0; i < N_VID; i++) begin
            pal_dout  = data_t'(lfsr_bits(8));
            char_dout = data_t'(lfsr_bits(8));
            com_dout  = data_t'(lfsr_bits(8));
            obj_dout  = data_t'(lfsr_bits(8));
            scr_dout  = data_t'(lfsr_bits(8));
            win       = int'(lfsr_bits(3)) % 5;
            a         = addr_t'(16'h1000 + win * 16'h0800) | addr_t'(lfsr_bits(11));
            bus_cycle(1'b0, a, 8'h00, 0, rd);
            case (win)
                0:       exp_d = pal_dout;
                1:       exp_d = char_dout;
                2:       exp_d = com_dout;
                3:       exp_d = obj_dout;
                default: exp_d = scr_dout;
            endcase
            check_value("read data", 32'(exp_d), 32'(rd));
        end

        // Random offsets first, then every offset once
        test_name = "cabinet";
        for (int i = 0; i < N_IO + 8; i++) begin
            start_button = 2'(lfsr_bits(2));
            coin_input   = 2'(lfsr_bits(2));
            joystick1    = 7'(lfsr_bits(7));
            joystick2    = 7'(lfsr_bits(7));
            service      = 1'(lfsr_bits(1));
            mcu_ban      = 1'(lfsr_bits(1));
            vbl          = 1'(lfsr_bits(1));
            dipsw_a      = data_t'(lfsr_bits(8));
            dipsw_b      = data_t'(lfsr_bits(8));
            a            = {5'b00111, 11'(lfsr_bits(11))};
            if (i >= N_IO) begin
                a[2:0] = 3'(i - N_IO);
            end
            bus_cycle(1'b0, a, 8'h00, 0, rd);
            check_value("read data", 32'(cabinet_byte(a[2:0])), 32'(rd));
        end

        // Rising sources set, writes to 3, 4 and 5 clear
        test_name = "interrupts";
        prev_src  = source_levels();
        for (int i = 0; i < N_IRQ; i++) begin
            vbl         = 1'(lfsr_bits(1));
            dip_pause   = 1'(lfsr_bits(1));
            ims         = 1'(lfsr_bits(1));
            mcu_irqmain = 1'(lfsr_bits(1));
            src         = source_levels();
            exp_irqv    = exp_irqv | (src & ~prev_src);
            prev_src    = src;
            @(negedge clk);
            check_value("latched vector", 32'(exp_irqv), 32'({nmi, firq, irq}));
            sel = lfsr_bits(2);
            if (sel != 32'd0) begin
                reg_write(WR_NMI_CLR + int'(sel) - 1, data_t'(lfsr_bits(8)));
            end
            if (lfsr_bits(3) == 32'd0) begin
                reg_write(WR_MCU_NMI, data_t'(lfsr_bits(8)));
            end
        end

        test_name = "end";
        @(negedge clk);
        if (uut.u_chk.fail_count != 0) begin
            abort_run("A bound assertion on the bus failed");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* main_bus.f */
source/main_pkg.sv
source/main_decode.sv
source/main_regs.sv
source/irq_latch.sv
source/work_ram.sv
source/cabinet_io.sv
source/main_bus.sv
tests/main_bus_chk.sv
tests/tb_main_bus.sv
